//--- compile.f
+incdir+.
core_pkg.sv
inst_decode.sv
reg_alias_table.sv
rename_dispatch.sv
issue_queue.sv
int_execute.sv
result_bus.sv
core_top.sv
core_asserts.sv
tb_core.sv

//--- run_sim.sh
#!/bin/bash
# build the core slice testbench with Verilator, run it and check the log

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_core \
  -Mdir obj_dir > build.log 2>&1 \
  && ./obj_dir/Vtb_core > sim.log 2>&1 \
  || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "^ALL CHECKS PASSED$" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed, see sim.log"; exit 1; }

//--- tb_core.sv
// testbench for the core slice with random programs checked against an in-order model
`timescale 1ns/100ps
`include "core_settings.svh"

module tb_core;
  import core_pkg::*;

  logic              clk;
  logic              rst_n;
  logic              inst_valid;
  logic [31:0]       inst_word;
  logic [`XLEN-1:0]  inst_pc;
  logic [`TAG_W-1:0] inst_tag;
  logic              inst_stall;
  logic              result_valid;
  logic [`TAG_W-1:0] result_tag;
  logic [`XLEN-1:0]  result_value;

  integer            seed = 78567;
  int                errors = 0;
  int                sent_cnt = 0;
  int                done_cnt = 0;
  int                stall_cycles = 0;
  int                cyc = 0;
  int                stalls_before;
  int                guard;
  logic [`XLEN-1:0]  pc;
  logic [31:0]       regs [8];
  logic [31:0]       exp_val [64];
  logic              inflight [64];
  logic              lui_due_on [64];
  logic [5:0]        lui_due_tag [64];
  logic [5:0]        next_tag = '0;

  core_top UUT (
    .clk, .rst_n, .inst_valid, .inst_word, .inst_pc, .inst_tag,
    .inst_stall, .result_valid, .result_tag, .result_value
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic int unsigned rnd(input int unsigned n);
    rnd = $unsigned($random(seed)) % n;
  endfunction

  // RV32I integer semantics for OP and OP-IMM
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic is_reg, input logic [31:0] a,
                                          input logic [31:0] b);
    case (f3)
      3'd0:    alu_ref = (is_reg && alt) ? a - b : a + b;
      3'd1:    alu_ref = a << b[4:0];
      3'd2:    alu_ref = {31'b0, $signed(a) < $signed(b)};
      3'd3:    alu_ref = {31'b0, a < b};
      3'd4:    alu_ref = a ^ b;
      3'd5:    alu_ref = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    alu_ref = a | b;
      default: alu_ref = a & b;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
    if (got !== expv) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expv);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("errors: %0d", errors + 1);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // chain mode keeps every source and destination on x1 or x2
  task automatic send_one(input logic chain);
    int          cls;
    logic [4:0]  rd, rs1, rs2, shamt;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] word, b, expv;
    int          wait_cnt;
    rd = 5'(rnd(8));
    rs1 = 5'(rnd(8));
    rs2 = 5'(rnd(8));
    cls = int'(rnd(4));
    if (chain) begin
      rd = 5'(1 + rnd(2));
      rs1 = rd;
      rs2 = rd;
      cls = (rnd(8) == 0) ? 2 : int'(rnd(2));
    end
    f3 = 3'(rnd(8));
    shamt = 5'(rnd(32));
    imm12 = 12'(rnd(4096));
    imm20 = 20'($random(seed));
    alt = (f3 == 3'd0 || f3 == 3'd5) ? 1'(rnd(2)) : 1'b0;
    case (cls)
      0: begin
        word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
        expv = alu_ref(f3, alt, 1'b1, regs[rs1[2:0]], regs[rs2[2:0]]);
      end
      1: begin
        if (f3 == 3'd1) imm12 = {7'b0, shamt};
        if (f3 == 3'd5) imm12 = {1'b0, alt, 5'b0, shamt};
        alt = imm12[10];
        b = {{20{imm12[11]}}, imm12};
        word = {imm12, rs1, f3, rd, 7'b0010011};
        expv = alu_ref(f3, alt, 1'b0, regs[rs1[2:0]], b);
      end
      2: begin
        word = {imm20, rd, 7'b0110111};
        expv = {imm20, 12'b0};
      end
      default: begin
        word = {imm20, rd, 7'b0010111};
        expv = pc + {imm20, 12'b0};
      end
    endcase
    wait_cnt = 0;
    @(negedge clk);
    // input idles while no tag is free
    inst_valid = 1'b0;
    while ((sent_cnt - done_cnt) >= 48 || inflight[next_tag]) begin
      wait_cnt++;
      if (wait_cnt > 2000) stop_on_timeout("no room for another tag in flight");
      @(negedge clk);
    end
    inst_valid = 1'b1;
    inst_word = word;
    inst_pc = pc;
    inst_tag = next_tag;
    wait_cnt = 0;
    // stall is registered state, so its value now holds at the next edge
    while (inst_stall) begin
      wait_cnt++;
      if (wait_cnt > 2000) stop_on_timeout("core input stalled too long");
      @(negedge clk);
    end
    exp_val[next_tag] = expv;
    inflight[next_tag] = 1'b1;
    if (cls == 2) begin
      lui_due_tag[6'(cyc + 1)] = next_tag;
      lui_due_on[6'(cyc + 1)] = 1'b1;
    end
    if (rd != 5'd0) regs[rd[2:0]] = expv;
    sent_cnt++;
    next_tag = next_tag + 6'd1;
    pc = pc + 32'd4;
    @(posedge clk);
  endtask

  // result monitor sampling the registered outputs mid-cycle
  always @(negedge clk) begin
    if (rst_n) begin
      if (inst_stall) stall_cycles++;
      if (lui_due_on[6'(cyc)]) begin
        if (!inst_stall && !(result_valid && result_tag == lui_due_tag[6'(cyc)])) begin
          errors++;
          $display("LUI tag %0d gave no result one cycle after acceptance at %0t",
                   lui_due_tag[6'(cyc)], $time);
        end
        lui_due_on[6'(cyc)] = 1'b0;
      end
      if (result_valid) begin
        if (!inflight[result_tag]) begin
          errors++;
          $display("Result for tag %0d that was not in flight at %0t", result_tag, $time);
        end else begin
          check_value("result_value", result_value, exp_val[result_tag]);
          inflight[result_tag] = 1'b0;
          done_cnt++;
        end
      end
    end
  end

  initial begin
    for (int i = 0; i < 64; i++) begin
      inflight[i] = 1'b0;
      lui_due_on[i] = 1'b0;
      exp_val[i] = '0;
    end
    for (int i = 0; i < 8; i++) regs[i] = '0;
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst_word = '0;
    pc = 32'h0000_1000;
    inst_pc = pc;
    inst_tag = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("inst_stall", 32'(inst_stall), 32'd0);
    check_value("result_valid", 32'(result_valid), 32'd0);
    repeat (300) send_one(1'b0);
    stalls_before = stall_cycles;
    repeat (150) send_one(1'b1);
    @(negedge clk);
    inst_valid = 1'b0;
    if (stall_cycles == stalls_before) begin
      errors++;
      $display("inst_stall never rose during the dependency chain burst");
    end
    guard = 0;
    while (done_cnt != sent_cnt) begin
      guard++;
      if (guard > 5000) stop_on_timeout("results still missing for accepted tags");
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
    $display("errors: %0d, results: %0d of %0d", errors, done_cnt, sent_cnt);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- core_asserts.sv
// bound checks on rename credits, dispatch and issue readiness
`timescale 1ns/100ps
`include "core_settings.svh"

module core_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input logic [`CREDIT_W-1:0] credits,
  input logic                 dispatch_valid,
  input logic                 issue_valid,
  input logic                 operands_ready
);

  // an underflow wraps above IQ_DEPTH, so one bound covers both
  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= `CREDIT_W'(`IQ_DEPTH))
    else $error("credit counter out of range: %0d", credits);

  dispatch_credit: assert property (@(posedge clk) disable iff (!rst_n)
    dispatch_valid |-> credits != '0)
    else $error("dispatch with no credit left");

  issue_ready: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid |-> operands_ready)
    else $error("issue of an entry with a pending operand");

endmodule

bind rename_dispatch core_asserts u_rename_asserts (
  .clk(clk), .rst_n(rst_n), .credits(credits), .dispatch_valid(dispatch_valid),
  .issue_valid(1'b0), .operands_ready(1'b1)
);

// free queue slots mirror the rename credits
bind issue_queue core_asserts u_iq_asserts (
  .clk(clk), .rst_n(rst_n), .credits(`CREDIT_W'(`IQ_DEPTH) - `CREDIT_W'(count)),
  .dispatch_valid(dispatch_valid), .issue_valid(issue_valid),
  .operands_ready(ent[sel].rdy1 && ent[sel].rdy2)
);

//--- core_top.sv
// top level of the out-of-order integer core slice
`timescale 1ns/100ps
`include "core_settings.svh"

module core_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 inst_valid,
  input  logic [31:0]          inst_word,
  input  logic [`XLEN-1:0]     inst_pc,
  input  logic [`TAG_W-1:0]    inst_tag,
  output logic                 inst_stall,
  output logic                 result_valid,
  output logic [`TAG_W-1:0]    result_tag,
  output logic [`XLEN-1:0]     result_value
);
  import core_pkg::*;

  // decode to rename
  logic              rename_stall;
  logic              dec_valid, dec_uses_rs2, dec_forward;
  logic [`XLEN-1:0]  dec_pc, dec_imm;
  logic [`TAG_W-1:0] dec_tag;
  alu_op_t           dec_op;
  src_sel_t          dec_src1_sel;
  logic [4:0]        dec_rd, dec_rs1, dec_rs2;

  // rename and RAT
  logic [4:0]        rs1, rs2, alloc_rd;
  logic              rs1_ready, rs2_ready, rat_alloc;
  logic [`XLEN-1:0]  rs1_tagval, rs2_tagval;
  logic [`TAG_W-1:0] alloc_tag;

  // dispatch, issue and forwarding
  logic              dispatch_valid, disp_op1_ready, disp_op2_ready, credit_return;
  logic [`TAG_W-1:0] disp_tag, issue_tag, fwd_tag, alu_tag;
  alu_op_t           disp_op, issue_op;
  logic [`XLEN-1:0]  disp_op1, disp_op2, issue_a, issue_b, fwd_value, alu_value;
  logic              issue_valid, fwd_valid, fwd_busy, alu_valid;

  assign inst_stall = rename_stall;

  inst_decode u_decode (
    .clk, .rst_n, .inst_valid, .inst_word, .inst_pc, .inst_tag, .rename_stall,
    .dec_valid, .dec_pc, .dec_tag, .dec_op, .dec_src1_sel, .dec_uses_rs2,
    .dec_forward, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm
  );

  reg_alias_table u_rat (
    .clk, .rst_n, .rs1, .rs2, .rat_alloc, .alloc_rd, .alloc_tag,
    .result_valid, .result_tag, .result_value,
    .rs1_ready, .rs1_tagval, .rs2_ready, .rs2_tagval
  );

  rename_dispatch u_rename (
    .clk, .rst_n, .dec_valid, .dec_pc, .dec_tag, .dec_op, .dec_src1_sel,
    .dec_uses_rs2, .dec_forward, .dec_rd, .dec_rs1, .dec_rs2, .dec_imm,
    .rs1_ready, .rs1_tagval, .rs2_ready, .rs2_tagval, .credit_return, .fwd_busy,
    .result_valid, .result_tag, .result_value,
    .rename_stall, .rs1, .rs2, .rat_alloc, .alloc_rd, .alloc_tag,
    .dispatch_valid, .disp_tag, .disp_op, .disp_op1_ready, .disp_op1,
    .disp_op2_ready, .disp_op2, .fwd_valid, .fwd_tag, .fwd_value
  );

  issue_queue u_iq (
    .clk, .rst_n, .dispatch_valid, .disp_tag, .disp_op, .disp_op1_ready, .disp_op1,
    .disp_op2_ready, .disp_op2, .result_valid, .result_tag, .result_value,
    .issue_valid, .issue_tag, .issue_op, .issue_a, .issue_b, .credit_return
  );

  int_execute u_exe (
    .clk, .rst_n, .issue_valid, .issue_tag, .issue_op, .issue_a, .issue_b,
    .alu_valid, .alu_tag, .alu_value
  );

  result_bus u_result (
    .alu_valid, .alu_tag, .alu_value, .fwd_valid, .fwd_tag, .fwd_value,
    .fwd_busy, .result_valid, .result_tag, .result_value
  );

endmodule

//--- result_bus.sv
// result bus merging ALU and forwarded results into one broadcast
`timescale 1ns/100ps
`include "core_settings.svh"

module result_bus (
  input  logic                 alu_valid,
  input  logic [`TAG_W-1:0]    alu_tag,
  input  logic [`XLEN-1:0]     alu_value,
  input  logic                 fwd_valid,
  input  logic [`TAG_W-1:0]    fwd_tag,
  input  logic [`XLEN-1:0]     fwd_value,
  output logic                 fwd_busy,
  output logic                 result_valid,
  output logic [`TAG_W-1:0]    result_tag,
  output logic [`XLEN-1:0]     result_value
);

  // ALU always owns the bus when it has a result
  assign fwd_busy     = alu_valid;
  assign result_valid = alu_valid | fwd_valid;
  assign result_tag   = alu_valid ? alu_tag : fwd_tag;
  assign result_value = alu_valid ? alu_value : fwd_value;

endmodule

//--- int_execute.sv
// one-cycle integer ALU stage with registered result and tag
`timescale 1ns/100ps
`include "core_settings.svh"

module int_execute (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 issue_valid,
  input  logic [`TAG_W-1:0]    issue_tag,
  input  core_pkg::alu_op_t    issue_op,
  input  logic [`XLEN-1:0]     issue_a,
  input  logic [`XLEN-1:0]     issue_b,
  output logic                 alu_valid,
  output logic [`TAG_W-1:0]    alu_tag,
  output logic [`XLEN-1:0]     alu_value
);
  import core_pkg::*;

  logic [4:0]       shamt;
  logic [`XLEN-1:0] res;

  assign shamt = issue_b[4:0];

  always_comb begin
    case (issue_op)
      ALU_ADD:  res = issue_a + issue_b;
      ALU_SUB:  res = issue_a - issue_b;
      ALU_SLL:  res = issue_a << shamt;
      ALU_SLT:  res = `XLEN'($signed(issue_a) < $signed(issue_b));
      ALU_SLTU: res = `XLEN'(issue_a < issue_b);
      ALU_XOR:  res = issue_a ^ issue_b;
      ALU_SRL:  res = issue_a >> shamt;
      ALU_SRA:  res = $signed(issue_a) >>> shamt;
      ALU_OR:   res = issue_a | issue_b;
      ALU_AND:  res = issue_a & issue_b;
      // pass_b
      default:  res = issue_b;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_valid <= 1'b0;
    end else begin
      alu_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    alu_tag   <= issue_tag;
    alu_value <= res;
  end

endmodule

//--- issue_queue.sv
// collapsing issue queue with result wakeup, oldest-ready issue and credit return
`timescale 1ns/100ps
`include "core_settings.svh"

module issue_queue (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 dispatch_valid,
  input  logic [`TAG_W-1:0]    disp_tag,
  input  core_pkg::alu_op_t    disp_op,
  input  logic                 disp_op1_ready,
  input  logic [`XLEN-1:0]     disp_op1,
  input  logic                 disp_op2_ready,
  input  logic [`XLEN-1:0]     disp_op2,
  input  logic                 result_valid,
  input  logic [`TAG_W-1:0]    result_tag,
  input  logic [`XLEN-1:0]     result_value,
  output logic                 issue_valid,
  output logic [`TAG_W-1:0]    issue_tag,
  output core_pkg::alu_op_t    issue_op,
  output logic [`XLEN-1:0]     issue_a,
  output logic [`XLEN-1:0]     issue_b,
  output logic                 credit_return
);
  import core_pkg::*;

  localparam int IDX_W = $clog2(`IQ_DEPTH);
  localparam int CNT_W = $clog2(`IQ_DEPTH + 1);

  // an operand that is not ready holds the producer tag in its low bits
  typedef struct packed {
    logic [`TAG_W-1:0] tag;
    alu_op_t           op;
    logic              rdy1;
    logic [`XLEN-1:0]  val1;
    logic              rdy2;
    logic [`XLEN-1:0]  val2;
  } iq_entry_t;

  // slot 0 is the oldest entry
  iq_entry_t        ent   [`IQ_DEPTH];
  iq_entry_t        woken [`IQ_DEPTH];
  iq_entry_t        nxt   [`IQ_DEPTH];
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] wr_pos;
  logic [IDX_W-1:0] sel;

  // lowest ready slot wins, scanning from the top down
  always_comb begin
    issue_valid = 1'b0;
    sel         = '0;
    for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
      if (CNT_W'(i) < count && ent[i].rdy1 && ent[i].rdy2) begin
        issue_valid = 1'b1;
        sel         = IDX_W'(i);
      end
    end
  end

  assign issue_tag     = ent[sel].tag;
  assign issue_op      = ent[sel].op;
  assign issue_a       = ent[sel].val1;
  assign issue_b       = ent[sel].val2;
  assign credit_return = issue_valid;
  assign wr_pos        = count - CNT_W'(issue_valid);

  always_comb begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      woken[i] = ent[i];
      if (result_valid && !ent[i].rdy1 && ent[i].val1[`TAG_W-1:0] == result_tag) begin
        woken[i].rdy1 = 1'b1;
        woken[i].val1 = result_value;
      end
      if (result_valid && !ent[i].rdy2 && ent[i].val2[`TAG_W-1:0] == result_tag) begin
        woken[i].rdy2 = 1'b1;
        woken[i].val2 = result_value;
      end
    end
    // close the gap left by the issued entry, then append
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      nxt[i] = woken[i];
    end
    for (int i = 0; i < `IQ_DEPTH - 1; i++) begin
      if (issue_valid && IDX_W'(i) >= sel) begin
        nxt[i] = woken[i + 1];
      end
    end
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      if (dispatch_valid && CNT_W'(i) == wr_pos) begin
        nxt[i] = '{tag: disp_tag, op: disp_op, rdy1: disp_op1_ready, val1: disp_op1,
                   rdy2: disp_op2_ready, val2: disp_op2};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      count <= wr_pos + CNT_W'(dispatch_valid);
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `IQ_DEPTH; i++) begin
      ent[i] <= nxt[i];
    end
  end

endmodule

//--- rename_dispatch.sv
// rename stage building operands, forwarding LUI results and dispatching under credits
`timescale 1ns/100ps
`include "core_settings.svh"

module rename_dispatch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 dec_valid,
  input  logic [`XLEN-1:0]     dec_pc,
  input  logic [`TAG_W-1:0]    dec_tag,
  input  core_pkg::alu_op_t    dec_op,
  input  core_pkg::src_sel_t   dec_src1_sel,
  input  logic                 dec_uses_rs2,
  input  logic                 dec_forward,
  input  logic [4:0]           dec_rd,
  input  logic [4:0]           dec_rs1,
  input  logic [4:0]           dec_rs2,
  input  logic [`XLEN-1:0]     dec_imm,
  input  logic                 rs1_ready,
  input  logic [`XLEN-1:0]     rs1_tagval,
  input  logic                 rs2_ready,
  input  logic [`XLEN-1:0]     rs2_tagval,
  input  logic                 credit_return,
  input  logic                 fwd_busy,
  input  logic                 result_valid,
  input  logic [`TAG_W-1:0]    result_tag,
  input  logic [`XLEN-1:0]     result_value,
  output logic                 rename_stall,
  output logic [4:0]           rs1,
  output logic [4:0]           rs2,
  output logic                 rat_alloc,
  output logic [4:0]           alloc_rd,
  output logic [`TAG_W-1:0]    alloc_tag,
  output logic                 dispatch_valid,
  output logic [`TAG_W-1:0]    disp_tag,
  output core_pkg::alu_op_t    disp_op,
  output logic                 disp_op1_ready,
  output logic [`XLEN-1:0]     disp_op1,
  output logic                 disp_op2_ready,
  output logic [`XLEN-1:0]     disp_op2,
  output logic                 fwd_valid,
  output logic [`TAG_W-1:0]    fwd_tag,
  output logic [`XLEN-1:0]     fwd_value
);
  import core_pkg::*;

  logic [`CREDIT_W-1:0] credits;
  logic                 byp1, byp2;
  logic                 src1_ready, src2_ready;
  logic [`XLEN-1:0]     src1_val, src2_val;
  logic                 go;

  assign rs1 = dec_rs1;
  assign rs2 = dec_rs2;

  // catch a producer broadcasting in the same cycle as the RAT read
  assign byp1       = result_valid && !rs1_ready && rs1_tagval[`TAG_W-1:0] == result_tag;
  assign byp2       = result_valid && !rs2_ready && rs2_tagval[`TAG_W-1:0] == result_tag;
  assign src1_ready = rs1_ready | byp1;
  assign src1_val   = byp1 ? result_value : rs1_tagval;
  assign src2_ready = rs2_ready | byp2;
  assign src2_val   = byp2 ? result_value : rs2_tagval;

  always_comb begin
    case (dec_src1_sel)
      SRC_PC: begin
        disp_op1_ready = 1'b1;
        disp_op1       = dec_pc;
      end
      SRC_ZERO: begin
        disp_op1_ready = 1'b1;
        disp_op1       = '0;
      end
      default: begin
        disp_op1_ready = src1_ready;
        disp_op1       = src1_val;
      end
    endcase
    // OP reads rs2, everything else takes the immediate
    if (dec_uses_rs2) begin
      disp_op2_ready = src2_ready;
      disp_op2       = src2_val;
    end else begin
      disp_op2_ready = 1'b1;
      disp_op2       = dec_imm;
    end
  end

  // forwards wait on the ALU, queue-bound instructions on credits
  assign rename_stall   = dec_valid && (dec_forward ? fwd_busy : (credits == '0));
  assign go             = dec_valid && !rename_stall;
  assign dispatch_valid = go && !dec_forward;
  assign fwd_valid      = go && dec_forward;
  assign disp_tag       = dec_tag;
  assign disp_op        = dec_op;
  assign fwd_tag        = dec_tag;
  assign fwd_value      = dec_imm;

  assign rat_alloc = go && (dec_rd != 5'd0);
  assign alloc_rd  = dec_rd;
  assign alloc_tag = dec_tag;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= `CREDIT_W'(`IQ_DEPTH);
    end else begin
      credits <= credits + `CREDIT_W'(credit_return) - `CREDIT_W'(dispatch_valid);
    end
  end

endmodule

//--- reg_alias_table.sv
// register alias table holding a value or producer tag per architectural register
`timescale 1ns/100ps
`include "core_settings.svh"

module reg_alias_table (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [4:0]           rs1,
  input  logic [4:0]           rs2,
  input  logic                 rat_alloc,
  input  logic [4:0]           alloc_rd,
  input  logic [`TAG_W-1:0]    alloc_tag,
  input  logic                 result_valid,
  input  logic [`TAG_W-1:0]    result_tag,
  input  logic [`XLEN-1:0]     result_value,
  output logic                 rs1_ready,
  output logic [`XLEN-1:0]     rs1_tagval,
  output logic                 rs2_ready,
  output logic [`XLEN-1:0]     rs2_tagval
);

  // tagval is the value when ready, else the producer tag in the low bits
  logic             ready  [32];
  logic [`XLEN-1:0] tagval [32];

  // x0 reads as a ready zero
  assign rs1_ready  = (rs1 == 5'd0) | ready[rs1];
  assign rs1_tagval = (rs1 == 5'd0) ? '0 : tagval[rs1];
  assign rs2_ready  = (rs2 == 5'd0) | ready[rs2];
  assign rs2_tagval = (rs2 == 5'd0) ? '0 : tagval[rs2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        ready[i]  <= 1'b1;
        tagval[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 32; i++) begin
        if (result_valid && !ready[i] && tagval[i][`TAG_W-1:0] == result_tag) begin
          ready[i]  <= 1'b1;
          tagval[i] <= result_value;
        end
      end
      // allocation comes last so it overrides a same-cycle result write
      if (rat_alloc) begin
        if (result_valid && result_tag == alloc_tag) begin
          // forwarded result completing in its own rename cycle
          ready[alloc_rd]  <= 1'b1;
          tagval[alloc_rd] <= result_value;
        end else begin
          ready[alloc_rd]  <= 1'b0;
          tagval[alloc_rd] <= `XLEN'(alloc_tag);
        end
      end
    end
  end

endmodule

//--- inst_decode.sv
// registered RV32I decoder for OP, OP-IMM, LUI and AUIPC
`timescale 1ns/100ps
`include "core_settings.svh"

module inst_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 inst_valid,
  input  logic [31:0]          inst_word,
  input  logic [`XLEN-1:0]     inst_pc,
  input  logic [`TAG_W-1:0]    inst_tag,
  input  logic                 rename_stall,
  output logic                 dec_valid,
  output logic [`XLEN-1:0]     dec_pc,
  output logic [`TAG_W-1:0]    dec_tag,
  output core_pkg::alu_op_t    dec_op,
  output core_pkg::src_sel_t   dec_src1_sel,
  output logic                 dec_uses_rs2,
  output logic                 dec_forward,
  output logic [4:0]           dec_rd,
  output logic [4:0]           dec_rs1,
  output logic [4:0]           dec_rs2,
  output logic [`XLEN-1:0]     dec_imm
);
  import core_pkg::*;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic             alt;
  logic             legal;
  logic             uses_rs2;
  logic             forward;
  alu_op_t          op;
  src_sel_t         src1_sel;
  logic [`XLEN-1:0] imm;

  // funct3 map shared by OP and OP-IMM, sub only exists in OP
  function automatic alu_op_t funct_op(input logic [2:0] f3, input logic f7b5,
                                       input logic is_reg);
    case (f3)
      3'b000:  funct_op = (f7b5 && is_reg) ? ALU_SUB : ALU_ADD;
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = f7b5 ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  endfunction

  assign opcode = inst_word[6:0];
  assign funct3 = inst_word[14:12];
  assign alt    = inst_word[30];

  always_comb begin
    legal    = 1'b1;
    uses_rs2 = 1'b0;
    forward  = 1'b0;
    src1_sel = SRC_REG;
    op       = ALU_ADD;
    // I-type immediate unless a U-type class overrides it
    imm      = {{20{inst_word[31]}}, inst_word[31:20]};
    case (opcode)
      OPC_OP: begin
        uses_rs2 = 1'b1;
        op       = funct_op(funct3, alt, 1'b1);
      end
      OPC_OP_IMM: op = funct_op(funct3, alt, 1'b0);
      OPC_LUI: begin
        forward  = 1'b1;
        src1_sel = SRC_ZERO;
        op       = ALU_PASS_B;
        imm      = {inst_word[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        src1_sel = SRC_PC;
        imm      = {inst_word[31:12], 12'b0};
      end
      default: legal = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (!rename_stall) begin
      dec_valid <= inst_valid & legal;
    end
  end

  // stage payload held while rename is stalled
  always_ff @(posedge clk) begin
    if (!rename_stall) begin
      dec_pc       <= inst_pc;
      dec_tag      <= inst_tag;
      dec_op       <= op;
      dec_src1_sel <= src1_sel;
      dec_uses_rs2 <= uses_rs2;
      dec_forward  <= forward;
      dec_rd       <= inst_word[11:7];
      dec_rs1      <= inst_word[19:15];
      dec_rs2      <= inst_word[24:20];
      dec_imm      <= imm;
    end
  end

endmodule

//--- core_pkg.sv
// shared opcode constants, ALU operations and operand selects of the core slice
package core_pkg;

  // major opcodes of the supported classes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

  // integer ALU operations
  typedef enum logic [4:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // source of operand 1
  typedef enum logic [1:0] {
    SRC_REG,
    SRC_PC,
    SRC_ZERO
  } src_sel_t;

endpackage

//--- core_settings.svh
// global widths and issue queue sizing for the integer core slice
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path width
`define XLEN 32

// instruction tag width, supplied by the source
`define TAG_W 6

// issue queue entries, also the credit count after reset
`define IQ_DEPTH 8

// credit counter must hold IQ_DEPTH
`define CREDIT_W 4

`endif
